// File: logic/bus_master.sv
// External bus master
`default_nettype none
`timescale 1ns/1ps

module bus_master import mem_pkg::*; (
   input  wire                clk,
   input  wire                reset_n,
   mem_req_if.master          fetch,
   mem_req_if.master          data,
   output logic [ADDR_W-1:0]  bus_addr,
   input  wire  [DATA_W-1:0]  rd_data,
   output logic               rd_req,
   input  wire                rd_ack,
   output logic [DATA_W-1:0]  wr_data,
   output logic               wr_enable
);

   typedef enum logic [2:0] {
      BM_IDLE,
      BM_BYTE,
      BM_WORD_L,
      BM_WORD_GAP,
      BM_WORD_H
   } bm_state_e;

   bm_state_e             state;
   logic                  grant_fetch;  // which requester owns the cycle in flight.
   logic                  fetch_ack;
   logic                  data_ack;
   logic [2*DATA_W-1:0]   rdata_q;

   logic                  pick_fetch;
   logic                  pick_valid;
   req_kind_e             pick_kind;
   logic [ADDR_W-1:0]     pick_addr;
   logic [DATA_W-1:0]     pick_wdata;

   // ##############################
   // arbitration
   // ##############################

   // no grant while an ack is out, since the requester still holds req in that cycle.
   assign pick_fetch = fetch.req; // fetch wins over data.
   assign pick_valid = (fetch.req | data.req) & ~(fetch_ack | data_ack);
   assign pick_kind  = pick_fetch ? fetch.kind  : data.kind;
   assign pick_addr  = pick_fetch ? fetch.addr  : data.addr;
   assign pick_wdata = pick_fetch ? fetch.wdata : data.wdata;

   assign fetch.ack   = fetch_ack;
   assign fetch.rdata = rdata_q;
   assign data.ack    = data_ack;
   assign data.rdata  = rdata_q;

   // ##############################
   // bus cycles
   // ##############################

   always_ff @(posedge clk) begin
      fetch_ack <= 1'b0;
      data_ack  <= 1'b0;
      wr_enable <= 1'b0;
      if (!reset_n) begin
         state       <= BM_IDLE;
         rd_req      <= 1'b0;
         grant_fetch <= 1'b0;
      end else begin
         case (state)
            BM_IDLE: begin
               if (pick_valid) begin
                  grant_fetch <= pick_fetch;
                  bus_addr    <= pick_addr;
                  if (pick_kind == WR_BYTE) begin
                     wr_data   <= pick_wdata; // the strobe carries its own ack.
                     wr_enable <= 1'b1;
                     fetch_ack <= pick_fetch;
                     data_ack  <= ~pick_fetch;
                  end else begin
                     rd_req <= 1'b1;
                     state  <= (pick_kind == RD_WORD) ? BM_WORD_L : BM_BYTE;
                  end
               end
            end
            BM_BYTE: begin
               if (rd_ack) begin
                  rdata_q   <= {{DATA_W{1'b0}}, rd_data};
                  rd_req    <= 1'b0;
                  fetch_ack <= grant_fetch;
                  data_ack  <= ~grant_fetch;
                  state     <= BM_IDLE;
               end
            end
            BM_WORD_L: begin
               if (rd_ack) begin
                  rdata_q[DATA_W-1:0] <= rd_data;
                  rd_req              <= 1'b0; // one idle cycle between the two bytes.
                  state               <= BM_WORD_GAP;
               end
            end
            BM_WORD_GAP: begin
               bus_addr <= bus_addr + 16'd1;
               rd_req   <= 1'b1;
               state    <= BM_WORD_H;
            end
            BM_WORD_H: begin
               if (rd_ack) begin
                  rdata_q[2*DATA_W-1:DATA_W] <= rd_data;
                  rd_req    <= 1'b0;
                  fetch_ack <= grant_fetch;
                  data_ack  <= ~grant_fetch;
                  state     <= BM_IDLE;
               end
            end
            default: state <= BM_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
// Processor definitions
`default_nettype none

package cpu_pkg;

   // ##############################
   // widths and reset
   // ##############################

   localparam int REG_W = 8; // the A and X registers are one byte wide.
   localparam int PC_W  = 16;

   typedef logic [PC_W-1:0]  addr_t;
   typedef logic [REG_W-1:0] byte_t;

   localparam addr_t RESET_VECTOR = 16'h0444; // first opcode fetch address.

   // ##############################
   // opcodes
   // ##############################

   // any byte not listed here runs as a one-byte no-operation.
   typedef enum logic [7:0] {
      OP_LDA_IMM  = 8'hA9,
      OP_LDX_IMM  = 8'hA2,
      OP_LDA_ABSX = 8'hBD,
      OP_INX      = 8'hE8,
      OP_JMP_ABS  = 8'h4C,
      OP_BNE      = 8'hD0,
      OP_STA_ABS  = 8'h8D
   } opcode_e;

   // ##############################
   // execute unit states
   // ##############################

   typedef enum logic [2:0] {
      IDLE,    // waiting for an opcode.
      OPERAND, // immediate byte or absolute word in flight.
      INDEXED, // second read at word plus X.
      WRITE,   // store strobe in flight.
      FINISH   // one cycle before inst_done.
   } exec_state_e;

endpackage

`default_nettype wire

// File: logic/exec_unit.sv
// Instruction execute unit
`default_nettype none
`timescale 1ns/1ps

module exec_unit import mem_pkg::*, cpu_pkg::*; (
   input  wire          clk,
   input  wire          reset_n,
   mem_req_if.requester data,
   input  wire          opcode_valid,
   input  wire byte_t   opcode,
   input  wire addr_t   pc,
   output logic         inst_done,
   output addr_t        pc_next
);

   exec_state_e   state;
   opcode_e       op_q;
   opcode_e       dec_op;
   logic          req_q;
   req_kind_e     kind_q;
   addr_t         addr_q;
   byte_t         wdata_q;

   byte_t         reg_a;
   byte_t         reg_x;
   logic          flag_z;

   byte_t         inx_x;
   byte_t         rd_byte;
   addr_t         branch_pc;

   assign data.req   = req_q;
   assign data.kind  = kind_q;
   assign data.addr  = addr_q;
   assign data.wdata = wdata_q;

   assign dec_op    = opcode_e'(opcode);
   assign inx_x     = reg_x + 8'd1;
   assign rd_byte   = data.rdata[7:0];
   assign branch_pc = pc + 16'd2 + {{8{rd_byte[7]}}, rd_byte}; // signed offset from pc+2.

   // ##############################
   // execute FSM
   // ##############################

   always_ff @(posedge clk) begin
      inst_done <= 1'b0;
      if (!reset_n) begin
         state  <= IDLE;
         req_q  <= 1'b0;
         reg_a  <= '0;
         reg_x  <= '0;
         flag_z <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (opcode_valid) begin
                  op_q   <= dec_op;
                  addr_q <= pc + 16'd1;
                  case (dec_op)
                     OP_LDA_IMM, OP_LDX_IMM: begin
                        req_q  <= 1'b1;
                        kind_q <= RD_BYTE;
                        state  <= OPERAND;
                     end
                     OP_LDA_ABSX, OP_JMP_ABS, OP_STA_ABS: begin
                        req_q  <= 1'b1;
                        kind_q <= RD_WORD;
                        state  <= OPERAND;
                     end
                     OP_BNE: begin
                        if (!flag_z) begin
                           req_q  <= 1'b1; // only a taken branch reads its offset.
                           kind_q <= RD_BYTE;
                           state  <= OPERAND;
                        end else begin
                           pc_next <= pc + 16'd2;
                           state   <= FINISH;
                        end
                     end
                     OP_INX: begin
                        reg_x   <= inx_x;
                        flag_z  <= (inx_x == 8'h00);
                        pc_next <= pc + 16'd1;
                        state   <= FINISH;
                     end
                     default: begin
                        pc_next <= pc + 16'd1;
                        state   <= FINISH;
                     end
                  endcase
               end
            end
            OPERAND: begin
               if (data.ack) begin
                  req_q <= 1'b0;
                  state <= FINISH;
                  case (op_q)
                     OP_LDA_IMM: begin
                        reg_a   <= rd_byte;
                        flag_z  <= (rd_byte == 8'h00);
                        pc_next <= pc + 16'd2;
                     end
                     OP_LDX_IMM: begin
                        reg_x   <= rd_byte;
                        flag_z  <= (rd_byte == 8'h00);
                        pc_next <= pc + 16'd2;
                     end
                     OP_JMP_ABS: pc_next <= data.rdata;
                     OP_LDA_ABSX: begin
                        kind_q <= RD_BYTE;
                        addr_q <= data.rdata + {8'h00, reg_x}; // wraps at 16 bits.
                        state  <= INDEXED;
                     end
                     OP_STA_ABS: begin
                        kind_q  <= WR_BYTE;
                        addr_q  <= data.rdata;
                        wdata_q <= reg_a;
                        pc_next <= pc + 16'd3;
                        state   <= WRITE;
                     end
                     default: pc_next <= branch_pc;
                  endcase
               end
            end
            // req was dropped after the operand ack and goes up again here.
            INDEXED, WRITE: begin
               if (!req_q) begin
                  req_q <= 1'b1;
               end else if (data.ack) begin
                  req_q <= 1'b0;
                  state <= FINISH;
                  if (state == INDEXED) begin
                     reg_a   <= rd_byte;
                     flag_z  <= (rd_byte == 8'h00);
                     pc_next <= pc + 16'd3;
                  end
               end
            end
            FINISH: begin
               inst_done <= 1'b1;
               state     <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/fetch_sequencer.sv
// Opcode fetch sequencer
`default_nettype none
`timescale 1ns/1ps

module fetch_sequencer import mem_pkg::*, cpu_pkg::*; (
   input  wire          clk,
   input  wire          reset_n,
   mem_req_if.requester fetch,
   output logic         opcode_valid,
   output byte_t        opcode,
   output addr_t        pc,
   input  wire          inst_done,
   input  wire addr_t   pc_next
);

   typedef enum logic [1:0] {
      F_BOOT,  // first cycle out of reset.
      F_FETCH, // opcode read in flight.
      F_WAIT   // instruction executing.
   } fetch_state_e;

   fetch_state_e   state;
   logic           req_q;
   addr_t          addr_q;

   // opcode fetches are always single byte reads.
   assign fetch.req   = req_q;
   assign fetch.kind  = RD_BYTE;
   assign fetch.addr  = addr_q;
   assign fetch.wdata = '0;

   // ##############################
   // sequencing
   // ##############################

   always_ff @(posedge clk) begin
      opcode_valid <= 1'b0;
      if (!reset_n) begin
         state <= F_BOOT;
         pc    <= RESET_VECTOR;
         req_q <= 1'b0;
      end else begin
         case (state)
            F_BOOT: begin
               req_q  <= 1'b1;
               addr_q <= pc;
               state  <= F_FETCH;
            end
            F_FETCH: begin
               if (fetch.ack) begin
                  req_q        <= 1'b0;
                  opcode       <= fetch.rdata[7:0];
                  opcode_valid <= 1'b1; // one cycle strobe to the execute unit.
                  state        <= F_WAIT;
               end
            end
            F_WAIT: begin
               if (inst_done) begin
                  pc     <= pc_next;
                  req_q  <= 1'b1; // next fetch goes straight out at the new pc.
                  addr_q <= pc_next;
                  state  <= F_FETCH;
               end
            end
            default: state <= F_BOOT;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
// Memory bus definitions
`default_nettype none

package mem_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // a word read returns the byte at addr in the low half and addr+1 in the high half.
   typedef enum logic [1:0] {
      RD_BYTE,
      RD_WORD,
      WR_BYTE
   } req_kind_e;

endpackage

`default_nettype wire

// File: logic/mem_req_if.sv
// Memory request channel
`default_nettype none
`timescale 1ns/1ps

interface mem_req_if import mem_pkg::*; ();

   logic                  req;   // held until ack is seen.
   req_kind_e             kind;
   logic [ADDR_W-1:0]     addr;
   logic [DATA_W-1:0]     wdata;
   logic                  ack;   // one cycle pulse.
   logic [2*DATA_W-1:0]   rdata;

   modport requester (
      output req,
      output kind,
      output addr,
      output wdata,
      input  ack,
      input  rdata
   );

   modport master (
      input  req,
      input  kind,
      input  addr,
      input  wdata,
      output ack,
      output rdata
   );

endinterface

`default_nettype wire

// File: logic/mini6502_top.sv
// Test processor top level
`default_nettype none
`timescale 1ns/1ps

module mini6502_top import mem_pkg::*; (
   input  wire                clk,
   input  wire                reset_n,
   output logic [ADDR_W-1:0]  bus_addr,
   input  wire  [DATA_W-1:0]  rd_data,
   output logic               rd_req,
   input  wire                rd_ack,
   output logic [DATA_W-1:0]  wr_data,
   output logic               wr_enable
);

   mem_req_if fetch_req ();
   mem_req_if data_req ();

   logic                opcode_valid;
   logic [DATA_W-1:0]   opcode;
   logic [ADDR_W-1:0]   pc;
   logic                inst_done;
   logic [ADDR_W-1:0]   pc_next;

   bus_master bus_master_inst (
      .clk       (clk),
      .reset_n   (reset_n),
      .fetch     (fetch_req),
      .data      (data_req),
      .bus_addr  (bus_addr),
      .rd_data   (rd_data),
      .rd_req    (rd_req),
      .rd_ack    (rd_ack),
      .wr_data   (wr_data),
      .wr_enable (wr_enable)
   );

   fetch_sequencer fetch_sequencer_inst (
      .clk          (clk),
      .reset_n      (reset_n),
      .fetch        (fetch_req),
      .opcode_valid (opcode_valid),
      .opcode       (opcode),
      .pc           (pc),
      .inst_done    (inst_done),
      .pc_next      (pc_next)
   );

   exec_unit exec_unit_inst (
      .clk          (clk),
      .reset_n      (reset_n),
      .data         (data_req),
      .opcode_valid (opcode_valid),
      .opcode       (opcode),
      .pc           (pc),
      .inst_done    (inst_done),
      .pc_next      (pc_next)
   );

endmodule

`default_nettype wire

// File: mini6502.f
logic/mem_pkg.sv
logic/cpu_pkg.sv
logic/mem_req_if.sv
logic/bus_master.sv
logic/fetch_sequencer.sv
logic/exec_unit.sv
logic/mini6502_top.sv
verif/mini6502_assert.sv
verif/mini6502_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the mini6502 testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG="Done: errors found"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module mini6502_tb -f mini6502.f -Mdir "$BUILD_DIR" -o mini6502_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

"./$BUILD_DIR/mini6502_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
   echo "test failed"
   exit 1
fi

echo "test passed"
exit 0

// File: verif/mini6502_assert.sv
// Bus protocol assertions
`default_nettype none
`timescale 1ns/1ps

module mini6502_assert import mem_pkg::*; (
   input wire                clk,
   input wire                reset_n,
   input wire [ADDR_W-1:0]   bus_addr,
   input wire                rd_req,
   input wire                rd_ack,
   input wire                wr_enable
);

   // a read holds its request and address until the memory answers.
   rd_held: assert property (@(posedge clk) disable iff (!reset_n)
      rd_req && !rd_ack |=> rd_req && $stable(bus_addr))
      else $error("rd_req dropped or bus_addr changed before rd_ack");

   no_write_in_read: assert property (@(posedge clk) disable iff (!reset_n)
      !(wr_enable && rd_req))
      else $error("wr_enable high during a read cycle");

   write_single: assert property (@(posedge clk) disable iff (!reset_n)
      wr_enable |=> !wr_enable)
      else $error("wr_enable high for more than one cycle");

   idle_in_reset: assert property (@(posedge clk)
      !reset_n && $past(!reset_n) |-> !rd_req && !wr_enable)
      else $error("bus active during reset");

endmodule

bind mini6502_top mini6502_assert mini6502_assert_inst (
   .clk       (clk),
   .reset_n   (reset_n),
   .bus_addr  (bus_addr),
   .rd_req    (rd_req),
   .rd_ack    (rd_ack),
   .wr_enable (wr_enable)
);

`default_nettype wire

// File: verif/mini6502_tb.sv
// Processor testbench
`default_nettype none
`timescale 1ns/1ps

module mini6502_tb import cpu_pkg::*; ();

   localparam int NUM_INST    = 2000;
   localparam int BUS_TIMEOUT = 200; // clock cycles allowed for one bus event.

   logic    clk;
   logic    reset_n;
   addr_t   bus_addr;
   byte_t   rd_data;
   logic    rd_req;
   logic    rd_ack;
   byte_t   wr_data;
   logic    wr_enable;

   byte_t   mem [0:65535];
   int      error_count;
   int      inst_count;
   logic    timed_out;

   addr_t   m_pc; // instruction-level model state.
   byte_t   m_a;
   byte_t   m_x;
   logic    m_z;

   logic    ev_write; // last bus event seen.
   addr_t   ev_addr;
   byte_t   ev_data;

   mini6502_top mini6502_top_inst (
      .clk       (clk),
      .reset_n   (reset_n),
      .bus_addr  (bus_addr),
      .rd_data   (rd_data),
      .rd_req    (rd_req),
      .rd_ack    (rd_ack),
      .wr_data   (wr_data),
      .wr_enable (wr_enable)
   );

   always #10 clk = ~clk;

   // ##############################
   // memory model
   // ##############################

   initial begin : mem_responder
      int wait_left;
      rd_ack    = 1'b0;
      rd_data   = 8'h00;
      wait_left = 0;
      forever begin
         @(posedge clk);
         #1;
         if (!reset_n || rd_ack) begin
            rd_ack    = 1'b0; // ack lasts one cycle.
            wait_left = 0;
         end else if (rd_req) begin
            if (wait_left == 0) begin
               wait_left = $urandom_range(4, 1);
            end
            wait_left--;
            if (wait_left == 0) begin
               rd_ack  = 1'b1;
               rd_data = mem[bus_addr];
            end
         end
      end
   end

   function automatic byte_t pick_opcode(input logic [2:0] sel);
      case (sel)
         3'd1:    pick_opcode = OP_LDX_IMM;
         3'd2:    pick_opcode = OP_LDA_ABSX;
         3'd3:    pick_opcode = OP_INX;
         3'd4:    pick_opcode = OP_JMP_ABS;
         3'd5:    pick_opcode = OP_BNE;
         3'd6:    pick_opcode = OP_STA_ABS;
         default: pick_opcode = OP_LDA_IMM;
      endcase
   endfunction

   task automatic fill_memory;
      logic [31:0] rnd;
      addr_t       a;
      a = 16'h0000;
      do begin
         rnd = $urandom;
         if (rnd[3:0] < 4'd9) begin
            mem[a] = pick_opcode(rnd[10:8]);
         end else if (rnd[3:0] < 4'd12) begin
            mem[a] = {8{rnd[4]}}; // 00 sets Z and FF pushes indexed reads past 16'hFFFF.
         end else begin
            mem[a] = rnd[23:16];
         end
         a = a + 16'd1;
      end while (a != 16'h0000);
   endtask

   // ##############################
   // checks
   // ##############################

   task automatic check_bus_idle;
      assert (rd_req === 1'b0) else begin
         error_count++;
         $display("Error at %0t: rd_req is %b, expected 0", $time, rd_req);
      end
      assert (wr_enable === 1'b0) else begin
         error_count++;
         $display("Error at %0t: wr_enable is %b, expected 0", $time, wr_enable);
      end
   endtask

   task automatic wait_bus_event;
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && !timed_out) begin
         @(negedge clk);
         if (rd_req && rd_ack) begin
            seen     = 1'b1;
            ev_write = 1'b0;
            ev_addr  = bus_addr;
         end else if (wr_enable) begin
            seen           = 1'b1;
            ev_write       = 1'b1;
            ev_addr        = bus_addr;
            ev_data        = wr_data;
            mem[bus_addr]  = wr_data;
         end else begin
            cycles++;
            if (cycles >= BUS_TIMEOUT) begin
               timed_out = 1'b1;
               error_count++;
               $display("Timeout: no bus cycle within %0d clock cycles", BUS_TIMEOUT);
            end
         end
      end
   endtask

   task automatic expect_read(input addr_t exp_addr, output byte_t value);
      if (!timed_out) wait_bus_event();
      if (!timed_out) begin
         assert (!ev_write) else begin
            error_count++;
            $display("Error at %0t: write seen where a read of %h was expected", $time, exp_addr);
         end
         assert (ev_addr == exp_addr) else begin
            error_count++;
            $display("Error at %0t: bus_addr is %h, expected %h", $time, ev_addr, exp_addr);
         end
      end
      value = mem[exp_addr];
   endtask

   task automatic expect_write(input addr_t exp_addr, input byte_t exp_data);
      if (!timed_out) wait_bus_event();
      if (!timed_out) begin
         assert (ev_write) else begin
            error_count++;
            $display("Error at %0t: read seen where a write to %h was expected", $time, exp_addr);
         end
         assert (ev_addr == exp_addr) else begin
            error_count++;
            $display("Error at %0t: bus_addr is %h, expected %h", $time, ev_addr, exp_addr);
         end
         assert (ev_data == exp_data) else begin
            error_count++;
            $display("Error at %0t: wr_data is %h, expected %h", $time, ev_data, exp_data);
         end
      end
   endtask

   task automatic read_word(input addr_t at, output addr_t word);
      byte_t lo;
      byte_t hi;
      expect_read(at, lo);
      expect_read(at + 16'd1, hi);
      word = {hi, lo};
   endtask

   // one instruction of the reference model, checked as the bus shows it.
   task automatic run_instruction;
      byte_t op;
      byte_t val;
      addr_t word;
      expect_read(m_pc, op);
      case (op)
         OP_LDA_IMM, OP_LDX_IMM: begin
            expect_read(m_pc + 16'd1, val);
            if (op == OP_LDA_IMM) m_a = val;
            else m_x = val;
            m_z  = (val == 8'h00);
            m_pc = m_pc + 16'd2;
         end
         OP_LDA_ABSX: begin
            read_word(m_pc + 16'd1, word);
            expect_read(word + {8'h00, m_x}, val);
            m_a  = val;
            m_z  = (val == 8'h00);
            m_pc = m_pc + 16'd3;
         end
         OP_STA_ABS: begin
            read_word(m_pc + 16'd1, word);
            expect_write(word, m_a);
            m_pc = m_pc + 16'd3;
         end
         OP_JMP_ABS: begin
            read_word(m_pc + 16'd1, word);
            m_pc = word;
         end
         OP_BNE: begin
            if (!m_z) begin
               expect_read(m_pc + 16'd1, val);
               m_pc = m_pc + 16'd2 + {{8{val[7]}}, val};
            end else begin
               m_pc = m_pc + 16'd2;
            end
         end
         OP_INX: begin
            m_x  = m_x + 8'd1;
            m_z  = (m_x == 8'h00);
            m_pc = m_pc + 16'd1;
         end
         default: m_pc = m_pc + 16'd1;
      endcase
   endtask

   // ##############################
   // main sequence
   // ##############################

   initial begin : main_seq
      logic [31:0] seed_ret;
      seed_ret    = $urandom(31);
      clk         = 1'b0;
      reset_n     = 1'b0;
      error_count = 0;
      inst_count  = 0;
      timed_out   = 1'b0;
      ev_write    = 1'b0;
      ev_addr     = 16'h0000;
      ev_data     = 8'h00;
      fill_memory();
      m_pc = RESET_VECTOR;
      m_a  = 8'h00;
      m_x  = 8'h00;
      m_z  = 1'b0;
      repeat (8) begin
         @(posedge clk);
         #1;
         check_bus_idle();
      end
      reset_n = 1'b1;
      @(negedge clk);
      check_bus_idle();
      while (inst_count < NUM_INST && !timed_out) begin
         run_instruction();
         inst_count++;
      end
      $display("Ran %0d instructions, %0d errors", inst_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
